// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= fetch_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Test OK

.PHONY: sim clean

# build, run, then look for the pass line in the captured output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
+incdir+include
hw/fetch_pkg.sv
hw/next_pc_sel.sv
hw/fetch_bus_master.sv
hw/inst_rom.sv
hw/fetch_top.sv
tb/fetch_tb.sv

// ==== hw/fetch_bus_master.sv ====
module fetch_bus_master (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic [63:0]           pc_i,
    output logic                  req_valid_o,
    output fetch_pkg::rd_req_t    req_o,
    input  logic                  req_ready_i,
    input  logic                  rsp_valid_i,
    input  fetch_pkg::rd_rsp_t    rsp_i,
    output logic                  rsp_ready_o,
    output logic                  accept_o,
    output logic                  fetch_valid_o,
    output fetch_pkg::fetch_out_t fetch_o
);

    import fetch_pkg::*;

    typedef enum logic [1:0] {
        ST_ISSUE,
        ST_REQ,
        ST_WAIT
    } state_e;

    state_e  state_q;
    rd_req_t req_q;
    logic    rsp_fire;
    logic    pc_match;

    assign req_valid_o = (state_q == ST_REQ);
    assign rsp_ready_o = (state_q == ST_WAIT);
    assign req_o       = req_q;

    assign rsp_fire = rsp_valid_i && rsp_ready_o;
    // pc may have moved on while the read was in flight
    assign pc_match = (req_q.addr == pc_i);
    assign accept_o = rsp_fire && pc_match;

    // one read outstanding at a time
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_ISSUE;
        end else begin
            case (state_q)
                ST_ISSUE: begin
                    state_q <= ST_REQ;
                end
                ST_REQ: begin
                    if (req_ready_i) begin
                        state_q <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (rsp_fire) begin
                        state_q <= ST_ISSUE;
                    end
                end
                default: begin
                    state_q <= ST_ISSUE;
                end
            endcase
        end
    end

    // address held through the handshake and the response compare
    always_ff @(posedge clk) begin
        if (state_q == ST_ISSUE) begin
            req_q.addr <= pc_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fetch_valid_o <= 1'b0;
        end else begin
            fetch_valid_o <= accept_o;
        end
    end

    // stale responses never reach the output
    always_ff @(posedge clk) begin
        if (accept_o) begin
            fetch_o.pc   <= req_q.addr;
            fetch_o.inst <= rsp_i.data[31:0];
        end
    end

    a_req_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        (req_valid_o && !req_ready_i) |=> (req_valid_o && $stable(req_o)));

    a_single_phase: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(req_valid_o && rsp_ready_o));

endmodule

// ==== hw/fetch_pkg.sv ====
package fetch_pkg;

    // redirect information from later pipeline stages
    typedef struct packed {
        logic        jal;
        logic        jalr;
        logic        branch;
        logic        trap;
        logic        stall;
        // branch compare result, zero means taken
        logic [63:0] alu_res;
        // pc of the redirecting instruction
        logic [63:0] pc;
        logic [63:0] imm;
        logic [63:0] rs1;
        logic [63:0] trap_vec;
    } redirect_t;

    // read request payload
    typedef struct packed {
        logic [63:0] addr;
    } rd_req_t;

    // read response payload
    typedef struct packed {
        logic [63:0] data;
    } rd_rsp_t;

    // instruction handed to decode
    typedef struct packed {
        logic [63:0] pc;
        logic [31:0] inst;
    } fetch_out_t;

endpackage

// ==== hw/fetch_top.sv ====
module fetch_top (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  fetch_pkg::redirect_t  redirect_i,
    output logic                  fetch_valid_o,
    output fetch_pkg::fetch_out_t fetch_o
);

    import fetch_pkg::*;

    logic [63:0] pc;
    logic        accept;
    logic        req_valid;
    logic        req_ready;
    logic        rsp_valid;
    logic        rsp_ready;
    rd_req_t     rd_req;
    rd_rsp_t     rd_rsp;

    next_pc_sel u_next_pc_sel (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .redirect_i (redirect_i),
        .accept_i   (accept),
        .pc_o       (pc)
    );

    fetch_bus_master u_fetch_bus_master (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .pc_i          (pc),
        .req_valid_o   (req_valid),
        .req_o         (rd_req),
        .req_ready_i   (req_ready),
        .rsp_valid_i   (rsp_valid),
        .rsp_i         (rd_rsp),
        .rsp_ready_o   (rsp_ready),
        .accept_o      (accept),
        .fetch_valid_o (fetch_valid_o),
        .fetch_o       (fetch_o)
    );

    inst_rom u_inst_rom (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .req_valid_i (req_valid),
        .req_i       (rd_req),
        .req_ready_o (req_ready),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rd_rsp),
        .rsp_ready_i (rsp_ready)
    );

endmodule

// ==== hw/inst_rom.sv ====
`include "fetch_defs.svh"

module inst_rom #(
    parameter int unsigned LATENCY = `FETCH_ROM_LATENCY
) (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               req_valid_i,
    input  fetch_pkg::rd_req_t req_i,
    output logic               req_ready_o,
    output logic               rsp_valid_o,
    output fetch_pkg::rd_rsp_t rsp_o,
    input  logic               rsp_ready_i
);

    localparam int CNT_W = $clog2(LATENCY + 1);

    logic             busy_q;
    logic             rsp_valid_q;
    logic [CNT_W-1:0] cnt_q;
    logic [63:0]      addr_q;
    logic [31:0]      word;

    // single entry, takes a new address only when empty
    assign req_ready_o = !busy_q && !rsp_valid_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q      <= 1'b0;
            rsp_valid_q <= 1'b0;
            cnt_q       <= '0;
        end else if (req_valid_i && req_ready_o) begin
            if (LATENCY == 1) begin
                rsp_valid_q <= 1'b1;
            end else begin
                busy_q <= 1'b1;
                cnt_q  <= CNT_W'(LATENCY - 1);
            end
        end else if (busy_q) begin
            // last count, data shows up next cycle
            if (cnt_q == CNT_W'(1)) begin
                busy_q      <= 1'b0;
                rsp_valid_q <= 1'b1;
            end
            cnt_q <= cnt_q - CNT_W'(1);
        end else if (rsp_valid_q && rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i && req_ready_o) begin
            addr_q <= req_i.addr;
        end
    end

    // contents derived from the address, upper half inverted
    assign word        = addr_q[31:0] ^ `FETCH_INST_KEY;
    assign rsp_o.data  = {~word, word};
    assign rsp_valid_o = rsp_valid_q;

    a_rsp_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        (rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_o)));

endmodule

// ==== hw/next_pc_sel.sv ====
`include "fetch_defs.svh"

module next_pc_sel (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  fetch_pkg::redirect_t redirect_i,
    input  logic                 accept_i,
    output logic [63:0]          pc_o
);

    logic        jump_taken;
    logic [63:0] jalr_sum;
    logic [63:0] pc_q;
    logic [63:0] pc_d;
    logic        jalr_path_q;

    // jal, or branch with zero compare result
    assign jump_taken = redirect_i.jal || (redirect_i.branch && (redirect_i.alu_res == '0));
    assign jalr_sum   = redirect_i.rs1 + redirect_i.imm;

    // fixed priority, sequential advance last
    always_comb begin
        pc_d = pc_q;
        if (jump_taken) begin
            pc_d = redirect_i.pc + redirect_i.imm;
        end else if (redirect_i.jalr) begin
            pc_d = {jalr_sum[63:1], 1'b0};
        end else if (redirect_i.trap) begin
            pc_d = redirect_i.trap_vec;
        end else if (accept_i && !redirect_i.stall) begin
            pc_d = pc_q + 64'd4;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= `FETCH_RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    // marks pcs that descend from a register jump target
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            jalr_path_q <= 1'b0;
        end else if (jump_taken || redirect_i.trap) begin
            jalr_path_q <= redirect_i.jalr && !jump_taken;
        end else if (redirect_i.jalr) begin
            jalr_path_q <= 1'b1;
        end
    end

    assign pc_o = pc_q;

    // only a register jump may leave bit 1 set, bit 0 never
    a_pc_align: assert property (@(posedge clk) disable iff (!arst_n_i)
        (pc_o[1:0] == 2'b00) || (jalr_path_q && (pc_o[0] == 1'b0)));

endmodule

// ==== include/fetch_defs.svh ====
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// first program counter after reset
`define FETCH_RESET_PC 64'h0000_0000_8000_0000

// cycles from address acceptance to read data valid
`define FETCH_ROM_LATENCY 3

// instruction word = low address bits xor key
`define FETCH_INST_KEY 32'h5a3c_96e1

`endif

// ==== tb/fetch_tb.sv ====
`include "fetch_defs.svh"

module fetch_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import fetch_pkg::*;

    logic        clk;
    logic        arst_n_i;
    redirect_t   redirect_i;
    logic        fetch_valid_o;
    fetch_out_t  fetch_o;

    logic [31:0] lcg_q = 32'h3d9c_fbce;
    int          err_cnt = 0;
    int          timeout_cnt = 0;
    int          del_cnt;

    // reference model state
    logic [63:0] exp_pc;
    logic        pend_q;
    logic [63:0] pend_pc;
    logic        stall_q;
    logic        first_q;

    fetch_top DUT (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .redirect_i    (redirect_i),
        .fetch_valid_o (fetch_valid_o),
        .fetch_o       (fetch_o)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_q = lcg_q * 32'd1664525 + 32'd1013904223;
        return lcg_q;
    endfunction

    function automatic logic redirect_taken(input redirect_t r);
        return r.jal || r.jalr || r.trap || (r.branch && (r.alu_res == 64'd0));
    endfunction

    // jump or taken branch first, then register jump, then trap
    function automatic logic [63:0] redirect_target(input redirect_t r);
        logic [63:0] reg_sum;
        reg_sum = r.rs1 + r.imm;
        if (r.jal || (r.branch && (r.alu_res == 64'd0))) begin
            return r.pc + r.imm;
        end
        if (r.jalr) begin
            return reg_sum & ~64'd1;
        end
        return r.trap_vec;
    endfunction

    function automatic void report_mismatch(input string sig, input logic [63:0] exp_v,
                                            input logic [63:0] act_v);
        $display("FAIL t=%0t %s expected %h actual %h", $time, sig, exp_v, act_v);
        err_cnt++;
    endfunction

    // a delivery carries the pc from before any redirect of its own accept edge
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            exp_pc  <= `FETCH_RESET_PC;
            pend_q  <= 1'b0;
            pend_pc <= '0;
            stall_q <= 1'b0;
            first_q <= 1'b1;
            del_cnt <= 0;
        end else begin
            if (pend_q) begin
                exp_pc <= pend_pc;
            end else if (fetch_valid_o && !stall_q) begin
                exp_pc <= exp_pc + 64'd4;
            end
            pend_q  <= redirect_taken(redirect_i);
            pend_pc <= redirect_target(redirect_i);
            stall_q <= redirect_i.stall;
            if (fetch_valid_o) begin
                first_q <= 1'b0;
                del_cnt <= del_cnt + 1;
            end
        end
    end

    a_first_pc: assert property (@(posedge clk) disable iff (!arst_n_i)
        (fetch_valid_o && first_q) |-> (fetch_o.pc == `FETCH_RESET_PC))
        else report_mismatch("fetch_o.pc", `FETCH_RESET_PC, $sampled(fetch_o.pc));

    a_pc_seq: assert property (@(posedge clk) disable iff (!arst_n_i)
        fetch_valid_o |-> (fetch_o.pc == exp_pc))
        else report_mismatch("fetch_o.pc", $sampled(exp_pc), $sampled(fetch_o.pc));

    a_inst_word: assert property (@(posedge clk) disable iff (!arst_n_i)
        fetch_valid_o |-> (fetch_o.inst == (exp_pc[31:0] ^ `FETCH_INST_KEY)))
        else report_mismatch("fetch_o.inst", {32'd0, $sampled(exp_pc[31:0]) ^
                             `FETCH_INST_KEY}, {32'd0, $sampled(fetch_o.inst)});

    a_strobe: assert property (@(posedge clk) disable iff (!arst_n_i)
        fetch_valid_o |=> !fetch_valid_o)
        else report_mismatch("fetch_valid_o", 64'd0, 64'd1);

    task automatic wait_deliveries(input int n, input string what);
        int target;
        int cycles;
        target = del_cnt + n;
        cycles = 0;
        while ((del_cnt < target) && (cycles < 200)) begin
            @(posedge clk);
            cycles++;
        end
        if (del_cnt < target) begin
            $display("timeout: %s gave no %0d deliveries in 200 cycles", what, n);
            timeout_cnt++;
        end
    endtask

    // one-cycle pulse after a random gap with target fields aligned
    task automatic pulse_redirect(input logic jal, input logic jalr, input logic branch,
                                  input logic trap, input logic [63:0] alu_res);
        logic [31:0] r;
        repeat (next_rand() % 4) @(posedge clk);
        r = next_rand();
        @(posedge clk);
        redirect_i.jal      <= jal;
        redirect_i.jalr     <= jalr;
        redirect_i.branch   <= branch;
        redirect_i.trap     <= trap;
        redirect_i.alu_res  <= alu_res;
        redirect_i.pc       <= {32'd0, next_rand() & 32'hffff_fffc};
        redirect_i.imm      <= {{52{r[11]}}, r[11:2], 2'b00};
        redirect_i.rs1      <= {32'd0, next_rand()};
        redirect_i.trap_vec <= {32'd0, next_rand() & 32'hffff_fffc};
        @(posedge clk);
        redirect_i.jal    <= 1'b0;
        redirect_i.jalr   <= 1'b0;
        redirect_i.branch <= 1'b0;
        redirect_i.trap   <= 1'b0;
    endtask

    task automatic set_stall(input logic level);
        @(posedge clk);
        redirect_i.stall <= level;
    endtask

    initial begin
        arst_n_i   = 1'b0;
        redirect_i = '0;
        repeat (8) @(posedge clk);
        arst_n_i <= 1'b1;
        wait_deliveries(6, "sequential fetch after reset");
        for (int i = 0; i < 3; i++) begin
            pulse_redirect(1'b1, 1'b0, 1'b0, 1'b0, 64'd0);
            wait_deliveries(3, "jump");
            pulse_redirect(1'b0, 1'b0, 1'b1, 1'b0, 64'd0);
            wait_deliveries(3, "taken branch");
            pulse_redirect(1'b0, 1'b0, 1'b1, 1'b0, {32'd0, next_rand()} | 64'd1);
            wait_deliveries(3, "branch not taken");
            pulse_redirect(1'b0, 1'b1, 1'b0, 1'b0, 64'd0);
            wait_deliveries(3, "register jump");
            pulse_redirect(1'b0, 1'b0, 1'b0, 1'b1, 64'd0);
            wait_deliveries(3, "trap");
            pulse_redirect(1'b1, 1'b1, 1'b0, 1'b1, 64'd0);
            wait_deliveries(3, "jump, register jump and trap together");
            pulse_redirect(1'b1, 1'b1, 1'b0, 1'b0, 64'd0);
            wait_deliveries(3, "jump with register jump");
            pulse_redirect(1'b0, 1'b1, 1'b0, 1'b1, 64'd0);
            wait_deliveries(3, "register jump with trap");
            pulse_redirect(1'b1, 1'b0, 1'b0, 1'b1, 64'd0);
            wait_deliveries(3, "jump with trap");
            pulse_redirect(1'b0, 1'b1, 1'b1, 1'b0, 64'd1);
            wait_deliveries(3, "register jump with branch not taken");
        end
        // pc held, then a redirect while held
        set_stall(1'b1);
        wait_deliveries(4, "stall");
        pulse_redirect(1'b1, 1'b0, 1'b0, 1'b0, 64'd0);
        wait_deliveries(4, "jump during stall");
        set_stall(1'b0);
        wait_deliveries(4, "release of stall");
        @(posedge clk);
        $display("fetch_tb: %0d deliveries, %0d errors, %0d timeouts",
                 del_cnt, err_cnt, timeout_cnt);
        if ((err_cnt == 0) && (timeout_cnt == 0)) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
